// File: common/divsqrt_pkg.sv
// --------------------
// Widths, payload types, status bit positions
// and the operation encoding of the divide/sqrt unit
// --------------------
`default_nettype none

package divsqrt_pkg;

  // --------------------
  // Widths and iteration counts
  // --------------------
  // Operand and result width
  localparam int unsigned OPERAND_WIDTH = 16;
  // One quotient bit per cycle
  localparam int unsigned ITER_DIV_CYCLES = OPERAND_WIDTH;
  // Two radicand bits per cycle
  localparam int unsigned ITER_SQRT_CYCLES = OPERAND_WIDTH / 2;

  // --------------------
  // Payload types
  // --------------------
  typedef logic [OPERAND_WIDTH-1:0] operand_t;
  // Identifier travelling with each operation
  typedef logic [3:0] tag_t;
  // Flag vector, see the bit indices below
  typedef logic [1:0] status_t;

  // Divide by zero
  localparam int unsigned STATUS_DZ = 1;
  // Inexact, nonzero remainder or non-perfect square
  localparam int unsigned STATUS_NX = 0;

  // Operation select
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

endpackage

`default_nettype wire

// File: common/divsqrt_ifs.sv
// --------------------
// Request, unit and response interfaces
// with their modports
// --------------------
`timescale 1ns/1ps
`default_nettype none

// Request handshake from the input pipe into the control
interface divsqrt_req_if;
  logic                  valid;
  logic                  ready;
  divsqrt_pkg::op_e      op;
  divsqrt_pkg::operand_t operand_a;
  divsqrt_pkg::operand_t operand_b;
  divsqrt_pkg::tag_t     tag;

  modport src (output valid, op, operand_a, operand_b, tag, input ready);
  modport dst (input valid, op, operand_a, operand_b, tag, output ready);
endinterface

// Control to iterative core
// Start pulses only while ready, done is a single-cycle pulse
interface divsqrt_unit_if;
  logic                  div_start;
  logic                  sqrt_start;
  divsqrt_pkg::operand_t operand_a;
  divsqrt_pkg::operand_t operand_b;
  logic                  kill;
  divsqrt_pkg::operand_t result;
  divsqrt_pkg::status_t  status;
  logic                  ready;
  logic                  done;

  modport ctrl (output div_start, sqrt_start, operand_a, operand_b, kill,
                input result, status, ready, done);
  modport core (input div_start, sqrt_start, operand_a, operand_b, kill,
                output result, status, ready, done);
endinterface

// Response handshake from the control into the output pipe
interface divsqrt_rsp_if;
  logic                  valid;
  logic                  ready;
  divsqrt_pkg::operand_t result;
  divsqrt_pkg::status_t  status;
  divsqrt_pkg::tag_t     tag;

  modport src (output valid, result, status, tag, input ready);
  modport dst (input valid, result, status, tag, output ready);
endinterface

`default_nettype wire

// File: verilog/divsqrt_in_pipe.sv
// --------------------
// Elastic input stages for requests
// Zero stages make it a pass-through
// --------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_in_pipe #(
  parameter int unsigned NumInpRegs = 1
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::operand_t operand_a_i,
  input  divsqrt_pkg::operand_t operand_b_i,
  input  divsqrt_pkg::tag_t     tag_i,
  output logic                  in_ready_o,
  output logic                  busy_o,
  divsqrt_req_if.src            req
);

  // Index i is the value after i stages
  logic                  [0:NumInpRegs] valid_q;
  logic                  [0:NumInpRegs] ready;
  logic                  [0:NumInpRegs] busy_chain;
  divsqrt_pkg::op_e      [0:NumInpRegs] op_q;
  divsqrt_pkg::operand_t [0:NumInpRegs] opa_q;
  divsqrt_pkg::operand_t [0:NumInpRegs] opb_q;
  divsqrt_pkg::tag_t     [0:NumInpRegs] tag_q;

  // Stage 0 is the port side
  assign valid_q[0]    = in_valid_i;
  assign op_q[0]       = op_i;
  assign opa_q[0]      = operand_a_i;
  assign opb_q[0]      = operand_b_i;
  assign tag_q[0]      = tag_i;
  assign busy_chain[0] = 1'b0;
  assign in_ready_o    = ready[0];

  for (genvar i = 0; i < NumInpRegs; i++) begin : gen_stage
    logic reg_en;
    // Advance when the next stage moves on or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign reg_en   = ready[i] & valid_q[i];

    // Valid bit, flush drops whatever sits here
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Request fields, enable only
    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        op_q[i+1]  <= op_q[i];
        opa_q[i+1] <= opa_q[i];
        opb_q[i+1] <= opb_q[i];
        tag_q[i+1] <= tag_q[i];
      end
    end

    // Any occupied stage counts as in flight
    assign busy_chain[i+1] = busy_chain[i] | valid_q[i+1];
  end

  // Last stage faces the control
  assign ready[NumInpRegs] = req.ready;
  assign req.valid         = valid_q[NumInpRegs];
  assign req.op            = op_q[NumInpRegs];
  assign req.operand_a     = opa_q[NumInpRegs];
  assign req.operand_b     = opb_q[NumInpRegs];
  assign req.tag           = tag_q[NumInpRegs];
  assign busy_o            = busy_chain[NumInpRegs];

endmodule

`default_nettype wire

// File: divsqrt_core/divsqrt_iter_unit.sv
// --------------------
// Bit-serial restoring divider and
// digit-by-digit square root engine
// --------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_iter_unit (
  input  logic          clk_i,
  input  logic          arst_n_i,
  divsqrt_unit_if.core  unit
);

  localparam int unsigned W     = divsqrt_pkg::OPERAND_WIDTH;
  // One spare bit for the trial subtraction
  localparam int unsigned RemW  = W + 1;
  localparam int unsigned RootW = W / 2;
  localparam int unsigned CntW  = $clog2(divsqrt_pkg::ITER_DIV_CYCLES);

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  state_e                state_q;
  logic [CntW-1:0]       cnt_q;
  logic                  start;
  logic                  last_iter;
  // Datapath registers
  logic                  is_sqrt_q;
  logic [RemW-1:0]       rem_q;
  logic [RemW-1:0]       rem_d;
  // Dividend shifting out, quotient shifting in, or radicand for sqrt
  divsqrt_pkg::operand_t acc_q;
  divsqrt_pkg::operand_t acc_d;
  logic [RootW-1:0]      root_q;
  logic [RootW-1:0]      root_d;
  divsqrt_pkg::operand_t divisor_q;
  // Iteration step
  logic [RemW-1:0]       shifted;
  logic [RemW-1:0]       trial;
  logic                  fits;
  logic                  div_zero;
  divsqrt_pkg::status_t  status;

  assign start = unit.div_start | unit.sqrt_start;

  // Last iteration runs combinationally in the done cycle
  assign last_iter = is_sqrt_q
                   ? (cnt_q == CntW'(divsqrt_pkg::ITER_SQRT_CYCLES - 1))
                   : (cnt_q == CntW'(divsqrt_pkg::ITER_DIV_CYCLES - 1));

  // --------------------
  // Iteration step
  // --------------------
  always_comb begin : step
    if (is_sqrt_q) begin
      // Bring down the next radicand bit pair
      shifted = {rem_q[RemW-3:0], acc_q[W-1 -: 2]};
      // Trial value 4*root + 1
      trial   = RemW'({root_q, 2'b01});
    end else begin
      // Bring down the next dividend bit
      shifted = {rem_q[RemW-2:0], acc_q[W-1]};
      trial   = RemW'(divisor_q);
    end
  end

  // Restore by keeping the shifted value when the trial does not fit
  assign fits   = shifted >= trial;
  assign rem_d  = fits ? shifted - trial : shifted;
  assign acc_d  = is_sqrt_q ? acc_q << 2 : {acc_q[W-2:0], fits};
  assign root_d = {root_q[RootW-2:0], fits};

  // --------------------
  // Result and flags
  // --------------------
  assign div_zero = ~is_sqrt_q & (divisor_q == '0);

  always_comb begin : flags
    status                        = '0;
    status[divsqrt_pkg::STATUS_DZ] = div_zero;
    // Exact remainder is meaningless for x/0
    status[divsqrt_pkg::STATUS_NX] = ~div_zero & (rem_d != '0);
  end

  // A zero divisor fits every trial so the quotient comes out all ones
  assign unit.result = is_sqrt_q ? W'(root_d) : acc_d;
  assign unit.status = status;
  assign unit.done   = (state_q == ST_RUN) & last_iter;
  // Back-to-back start allowed in the done cycle
  assign unit.ready  = (state_q == ST_IDLE) | unit.done;

  // --------------------
  // Sequencing
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin : seq_regs
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else if (unit.kill) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else if (start) begin
      state_q <= ST_RUN;
      cnt_q   <= '0;
    end else if (state_q == ST_RUN) begin
      if (last_iter) begin
        state_q <= ST_IDLE;
      end
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Operands load on start, then shift each running cycle
  always_ff @(posedge clk_i) begin : data_regs
    if (start) begin
      is_sqrt_q <= unit.sqrt_start;
      rem_q     <= '0;
      acc_q     <= unit.operand_a;
      root_q    <= '0;
      divisor_q <= unit.operand_b;
    end else if (state_q == ST_RUN) begin
      rem_q  <= rem_d;
      acc_q  <= acc_d;
      root_q <= root_d;
    end
  end

endmodule

`default_nettype wire

// File: divsqrt_core/divsqrt_ctrl.sv
// --------------------
// Control FSM around the iterative core
// Tag capture and result hold register
// --------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_ctrl (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          flush_i,
  output logic          busy_o,
  divsqrt_req_if.dst    req,
  divsqrt_unit_if.ctrl  unit,
  divsqrt_rsp_if.src    rsp
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    HOLD
  } state_e;

  state_e                state_q;
  state_e                state_d;
  logic                  fsm_ready;
  logic                  out_valid;
  logic                  unit_busy;
  logic                  op_start;
  logic                  hold_en;
  divsqrt_pkg::tag_t     tag_q;
  divsqrt_pkg::operand_t held_result_q;
  divsqrt_pkg::status_t  held_status_q;

  // --------------------
  // FSM
  // --------------------
  always_comb begin : fsm
    fsm_ready = 1'b0;
    out_valid = 1'b0;
    unit_busy = 1'b0;
    state_d   = state_q;

    unique case (state_q)
      // Waiting for work
      IDLE: begin
        fsm_ready = 1'b1;
      end
      // Core running
      BUSY: begin
        unit_busy = 1'b1;
        if (unit.done) begin
          out_valid = 1'b1;
          if (rsp.ready) begin
            // Result leaves now, next request may start this cycle
            fsm_ready = 1'b1;
            state_d   = IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      // Result parked, waiting for downstream
      HOLD: begin
        unit_busy = 1'b1;
        out_valid = 1'b1;
        if (rsp.ready) begin
          fsm_ready = 1'b1;
          state_d   = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // Start gated by the FSM and the core
    op_start = req.valid & fsm_ready & unit.ready & ~flush_i;
    if (op_start) begin
      state_d = BUSY;
    end

    // Flush wins over everything
    if (flush_i) begin
      unit_busy = 1'b0;
      out_valid = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : state_reg
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Core side
  // --------------------
  assign req.ready       = fsm_ready & unit.ready;
  assign unit.div_start  = op_start & (req.op == divsqrt_pkg::OP_DIV);
  assign unit.sqrt_start = op_start & (req.op == divsqrt_pkg::OP_SQRT);
  assign unit.operand_a  = req.operand_a;
  assign unit.operand_b  = req.operand_b;
  assign unit.kill       = flush_i;

  // Tag follows the operation through the core
  always_ff @(posedge clk_i) begin : tag_reg
    if (op_start) begin
      tag_q <= req.tag;
    end
  end

  // Capture the result only when done finds downstream stalled
  assign hold_en = unit.done & ~rsp.ready;

  always_ff @(posedge clk_i) begin : hold_reg
    if (hold_en) begin
      held_result_q <= unit.result;
      held_status_q <= unit.status;
    end
  end

  // --------------------
  // Response side
  // --------------------
  assign rsp.valid  = out_valid;
  assign rsp.result = (state_q == HOLD) ? held_result_q : unit.result;
  assign rsp.status = (state_q == HOLD) ? held_status_q : unit.status;
  assign rsp.tag    = tag_q;
  assign busy_o     = unit_busy;

endmodule

`default_nettype wire

// File: verilog/divsqrt_out_pipe.sv
// --------------------
// Elastic output stages for results,
// status and tag
// --------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_out_pipe #(
  parameter int unsigned NumOutRegs = 1
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  out_ready_i,
  divsqrt_rsp_if.dst            rsp,
  output logic                  out_valid_o,
  output divsqrt_pkg::operand_t result_o,
  output divsqrt_pkg::status_t  status_o,
  output divsqrt_pkg::tag_t     tag_o,
  output logic                  busy_o
);

  // Index i is the value after i stages
  logic                  [0:NumOutRegs] valid_q;
  logic                  [0:NumOutRegs] ready;
  logic                  [0:NumOutRegs] busy_chain;
  divsqrt_pkg::operand_t [0:NumOutRegs] result_q;
  divsqrt_pkg::status_t  [0:NumOutRegs] status_q;
  divsqrt_pkg::tag_t     [0:NumOutRegs] tag_q;

  // Stage 0 is the control side
  assign valid_q[0]    = rsp.valid;
  assign result_q[0]   = rsp.result;
  assign status_q[0]   = rsp.status;
  assign tag_q[0]      = rsp.tag;
  assign busy_chain[0] = 1'b0;
  assign rsp.ready     = ready[0];

  for (genvar i = 0; i < NumOutRegs; i++) begin : gen_stage
    logic reg_en;
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign reg_en   = ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        result_q[i+1] <= result_q[i];
        status_q[i+1] <= status_q[i];
        tag_q[i+1]    <= tag_q[i];
      end
    end

    assign busy_chain[i+1] = busy_chain[i] | valid_q[i+1];
  end

  // Downstream ready enters at the last stage
  assign ready[NumOutRegs] = out_ready_i;
  assign out_valid_o       = valid_q[NumOutRegs];
  assign result_o          = result_q[NumOutRegs];
  assign status_o          = status_q[NumOutRegs];
  assign tag_o             = tag_q[NumOutRegs];
  assign busy_o            = busy_chain[NumOutRegs];

endmodule

`default_nettype wire

// File: verilog/divsqrt_top.sv
// --------------------
// Divide/sqrt unit top level
// Input pipe, control, core, output pipe
// --------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_top #(
  parameter int unsigned NumInpRegs = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::operand_t operand_a_i,
  input  divsqrt_pkg::operand_t operand_b_i,
  input  divsqrt_pkg::tag_t     tag_i,
  input  logic                  flush_i,
  input  logic                  out_ready_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output divsqrt_pkg::operand_t result_o,
  output divsqrt_pkg::status_t  status_o,
  output divsqrt_pkg::tag_t     tag_o,
  output logic                  busy_o
);

  logic in_busy;
  logic ctrl_busy;
  logic out_busy;

  divsqrt_req_if  req_if ();
  divsqrt_unit_if unit_if ();
  divsqrt_rsp_if  rsp_if ();

  divsqrt_in_pipe #(
    .NumInpRegs ( NumInpRegs )
  ) i_in_pipe (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .op_i        ( op_i        ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .tag_i       ( tag_i       ),
    .in_ready_o  ( in_ready_o  ),
    .busy_o      ( in_busy     ),
    .req         ( req_if.src  )
  );

  divsqrt_ctrl i_ctrl (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .flush_i  ( flush_i      ),
    .busy_o   ( ctrl_busy    ),
    .req      ( req_if.dst   ),
    .unit     ( unit_if.ctrl ),
    .rsp      ( rsp_if.src   )
  );

  divsqrt_iter_unit i_iter_unit (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .unit     ( unit_if.core )
  );

  divsqrt_out_pipe #(
    .NumOutRegs ( NumOutRegs )
  ) i_out_pipe (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .flush_i     ( flush_i     ),
    .out_ready_i ( out_ready_i ),
    .rsp         ( rsp_if.dst  ),
    .out_valid_o ( out_valid_o ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .busy_o      ( out_busy    )
  );

  // Anything queued, computing or waiting to leave
  assign busy_o = in_busy | ctrl_busy | out_busy;

endmodule

`default_nettype wire

// File: bench/divsqrt_assertions.sv
// --------------------
// Concurrent assertions on the top level
// Flush, back-pressure stability, busy
// --------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_assertions (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  flush_i,
  input logic                  out_valid_i,
  input logic                  out_ready_i,
  input logic                  busy_i,
  input divsqrt_pkg::operand_t result_i,
  input divsqrt_pkg::status_t  status_i,
  input divsqrt_pkg::tag_t     tag_i
);

  // Flush empties the unit within one cycle
  a_flush_clears: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> (!out_valid_i && !busy_i))
    else $error("out_valid_o or busy_o still high one cycle after flush");

  // Stalled output holds still
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_i && !out_ready_i && !flush_i) |=>
      (out_valid_i && $stable(result_i) && $stable(status_i) && $stable(tag_i)))
    else $error("Output changed while stalled by out_ready_i");

  // A waiting result means the unit is busy
  a_busy_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i |-> busy_i)
    else $error("busy_o low while out_valid_o is high");

endmodule

bind divsqrt_top divsqrt_assertions i_assertions (
  .clk_i       ( clk_i       ),
  .arst_n_i    ( arst_n_i    ),
  .flush_i     ( flush_i     ),
  .out_valid_i ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .busy_i      ( busy_o      ),
  .result_i    ( result_o    ),
  .status_i    ( status_o    ),
  .tag_i       ( tag_o       )
);

`default_nettype wire

// File: bench/divsqrt_checker.sv
// --------------------
// Reference model and expected-result queue
// Compares every output transfer
// --------------------
`timescale 1ns/1ps
`default_nettype none

module divsqrt_checker (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  input  logic                  in_ready_i,
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::operand_t operand_a_i,
  input  divsqrt_pkg::operand_t operand_b_i,
  input  divsqrt_pkg::tag_t     tag_in_i,
  input  logic                  out_valid_i,
  input  logic                  out_ready_i,
  input  divsqrt_pkg::operand_t result_i,
  input  divsqrt_pkg::status_t  status_i,
  input  divsqrt_pkg::tag_t     tag_out_i,
  input  logic                  busy_i,
  output int unsigned           value_errors_o,
  output int unsigned           protocol_errors_o,
  output int unsigned           pending_o
);

  divsqrt_pkg::operand_t exp_result_q[$];
  divsqrt_pkg::status_t  exp_status_q[$];
  divsqrt_pkg::tag_t     exp_tag_q[$];
  int unsigned           value_errors = 0;
  int unsigned           protocol_errors = 0;
  int unsigned           pending = 0;
  logic                  reset_checked = 1'b0;

  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;
  assign pending_o         = pending;

  // --------------------
  // Reference model
  // --------------------
  function automatic void model_answer(input divsqrt_pkg::op_e op,
                                       input divsqrt_pkg::operand_t a,
                                       input divsqrt_pkg::operand_t b,
                                       output divsqrt_pkg::operand_t res,
                                       output divsqrt_pkg::status_t st);
    int unsigned root;
    st = '0;
    if (op == divsqrt_pkg::OP_DIV) begin
      if (b == '0) begin
        // Zero divisor gives all ones, DZ only
        res = '1;
        st[divsqrt_pkg::STATUS_DZ] = 1'b1;
      end else begin
        res = a / b;
        st[divsqrt_pkg::STATUS_NX] = (a % b) != '0;
      end
    end else begin
      // Largest root whose square fits in a
      root = 0;
      while ((root + 1) * (root + 1) <= int'(a)) begin
        root++;
      end
      res = divsqrt_pkg::operand_t'(root);
      st[divsqrt_pkg::STATUS_NX] = (root * root) != int'(a);
    end
  endfunction

  task automatic compare_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("** Error @ %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    end
  endtask

  // --------------------
  // Monitor on the rising edge
  // --------------------
  always @(posedge clk_i) begin : monitor
    divsqrt_pkg::operand_t res;
    divsqrt_pkg::status_t  st;
    if (!arst_n_i) begin
      exp_result_q.delete();
      exp_status_q.delete();
      exp_tag_q.delete();
    end else begin
      // First edge after reset release
      if (!reset_checked) begin
        compare_value("out_valid_o", 16'(1'b0), 16'(out_valid_i));
        compare_value("busy_o", 16'(1'b0), 16'(busy_i));
        compare_value("in_ready_o", 16'(1'b1), 16'(in_ready_i));
        reset_checked = 1'b1;
      end
      // Output side first, a result leaving in a flush cycle is still valid
      if (out_valid_i && out_ready_i) begin
        if (exp_tag_q.size() == 0) begin
          protocol_errors++;
          $display("Unexpected result at %0t with tag %0d, no request is pending",
                   $time, tag_out_i);
        end else begin
          compare_value("tag_o", 16'(exp_tag_q[0]), 16'(tag_out_i));
          compare_value("result_o", exp_result_q[0], result_i);
          compare_value("status_o", 16'(exp_status_q[0]), 16'(status_i));
          void'(exp_tag_q.pop_front());
          void'(exp_result_q.pop_front());
          void'(exp_status_q.pop_front());
        end
      end
      if (flush_i) begin
        // Nothing accepted so far may ever come out
        exp_result_q.delete();
        exp_status_q.delete();
        exp_tag_q.delete();
      end else if (in_valid_i && in_ready_i) begin
        model_answer(op_i, operand_a_i, operand_b_i, res, st);
        exp_result_q.push_back(res);
        exp_status_q.push_back(st);
        exp_tag_q.push_back(tag_in_i);
      end
    end
    pending = exp_tag_q.size();
  end

endmodule

`default_nettype wire

// File: bench/tb_divsqrt.sv
// --------------------
// Testbench top for the divide/sqrt unit
// Clock generator, reset, random requests,
// random back-pressure and flush pulses
// --------------------
`timescale 1ns/1ps
`default_nettype none

// Free-running clock, 4 ns period
module tb_clock_gen #(
  parameter int unsigned HalfPeriodNs = 2
) (
  output logic clk_o
);
  initial clk_o = 1'b0;
  always #(HalfPeriodNs) clk_o = ~clk_o;
endmodule

module tb_divsqrt;

  localparam int unsigned NumRequests = 300;
  // Cycles a request may wait for in_ready_o
  localparam int unsigned WaitLimit   = 200;
  // Cycles allowed for the final drain
  localparam int unsigned DrainLimit  = 2000;

  logic                  clk;
  logic                  arst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic                  flush;
  logic                  out_ready;
  logic                  out_valid;
  logic                  busy;
  divsqrt_pkg::op_e      op;
  divsqrt_pkg::operand_t operand_a;
  divsqrt_pkg::operand_t operand_b;
  divsqrt_pkg::operand_t result;
  divsqrt_pkg::status_t  status;
  divsqrt_pkg::tag_t     tag_in;
  divsqrt_pkg::tag_t     tag_out;
  int unsigned           value_errors;
  int unsigned           protocol_errors;
  int unsigned           pending;
  int unsigned           timeouts;
  logic                  timed_out;
  int unsigned           seed_ret;

  tb_clock_gen i_clock (.clk_o(clk));

  divsqrt_top #(
    .NumInpRegs ( 1 ),
    .NumOutRegs ( 2 )
  ) i_dut (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .in_valid_i  ( in_valid  ),
    .op_i        ( op        ),
    .operand_a_i ( operand_a ),
    .operand_b_i ( operand_b ),
    .tag_i       ( tag_in    ),
    .flush_i     ( flush     ),
    .out_ready_i ( out_ready ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( tag_out   ),
    .busy_o      ( busy      )
  );

  divsqrt_checker i_checker (
    .clk_i             ( clk             ),
    .arst_n_i          ( arst_n          ),
    .flush_i           ( flush           ),
    .in_valid_i        ( in_valid        ),
    .in_ready_i        ( in_ready        ),
    .op_i              ( op              ),
    .operand_a_i       ( operand_a       ),
    .operand_b_i       ( operand_b       ),
    .tag_in_i          ( tag_in          ),
    .out_valid_i       ( out_valid       ),
    .out_ready_i       ( out_ready       ),
    .result_i          ( result          ),
    .status_i          ( status          ),
    .tag_out_i         ( tag_out         ),
    .busy_i            ( busy            ),
    .value_errors_o    ( value_errors    ),
    .protocol_errors_o ( protocol_errors ),
    .pending_o         ( pending         )
  );

  // --------------------
  // Stimulus helpers
  // --------------------
  // Random op with a share of zero divisors, small divisors and perfect squares
  task automatic pick_operands(output divsqrt_pkg::op_e op_v,
                               output divsqrt_pkg::operand_t a_v,
                               output divsqrt_pkg::operand_t b_v);
    int unsigned sel;
    int unsigned root;
    sel  = $urandom % 8;
    op_v = ($urandom % 2 == 0) ? divsqrt_pkg::OP_DIV : divsqrt_pkg::OP_SQRT;
    a_v  = divsqrt_pkg::operand_t'($urandom);
    b_v  = divsqrt_pkg::operand_t'($urandom);
    if (op_v == divsqrt_pkg::OP_DIV) begin
      if (sel == 0) begin
        b_v = '0;
      end else if (sel < 3) begin
        b_v = divsqrt_pkg::operand_t'($urandom % 16);
      end
    end else if (sel < 3) begin
      root = $urandom % 256;
      a_v  = divsqrt_pkg::operand_t'(root * root);
    end
  endtask

  // Hold the request until in_ready_o, entered and left on a falling edge
  task automatic send_request(input divsqrt_pkg::op_e op_v,
                              input divsqrt_pkg::operand_t a_v,
                              input divsqrt_pkg::operand_t b_v,
                              input divsqrt_pkg::tag_t tag_v);
    int unsigned waited;
    waited    = 0;
    in_valid  = 1'b1;
    op        = op_v;
    operand_a = a_v;
    operand_b = b_v;
    tag_in    = tag_v;
    @(posedge clk);
    while (!in_ready && waited < WaitLimit) begin
      waited++;
      @(posedge clk);
    end
    if (!in_ready) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout at %0t: request with tag %0d was never accepted", $time, tag_v);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // Downstream accepts about 70 percent of cycles
  always @(negedge clk) begin
    out_ready = ($urandom % 10) < 7;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    divsqrt_pkg::op_e      op_v;
    divsqrt_pkg::operand_t a_v;
    divsqrt_pkg::operand_t b_v;
    divsqrt_pkg::tag_t     tag_v;
    int unsigned           gap;
    int unsigned           waited;
    seed_ret  = $urandom(32'he7b26b0c);
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    op        = divsqrt_pkg::OP_DIV;
    operand_a = '0;
    operand_b = '0;
    tag_in    = '0;
    flush     = 1'b0;
    out_ready = 1'b0;
    timeouts  = 0;
    timed_out = 1'b0;
    tag_v     = '0;

    // Reset held for 3 cycles, released on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int unsigned n = 0; n < NumRequests; n++) begin
      pick_operands(op_v, a_v, b_v);
      send_request(op_v, a_v, b_v, tag_v);
      if (timed_out) begin
        break;
      end
      tag_v++;
      // Occasional flush with no request on the port
      if ($urandom % 40 == 0) begin
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
      end
      gap = $urandom % 3;
      repeat (gap) @(negedge clk);
    end

    // Drain everything still in flight
    if (!timed_out) begin
      waited = 0;
      while ((pending != 0 || busy) && waited < DrainLimit) begin
        waited++;
        @(negedge clk);
      end
      if (pending != 0 || busy) begin
        timeouts++;
        $display("Timeout at %0t: %0d results never came out", $time, pending);
      end
    end

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
common/divsqrt_pkg.sv
common/divsqrt_ifs.sv
verilog/divsqrt_in_pipe.sv
divsqrt_core/divsqrt_iter_unit.sv
divsqrt_core/divsqrt_ctrl.sv
verilog/divsqrt_out_pipe.sv
verilog/divsqrt_top.sv
bench/divsqrt_assertions.sv
bench/divsqrt_checker.sv
bench/tb_divsqrt.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the success line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_divsqrt -o tb_divsqrt \
  && ./obj_dir/tb_divsqrt | tee /dev/stderr | grep -qx "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
